// ==== verilog/soc_bus_pkg.sv ====
`default_nettype none

// Request and response words of the host bus and of every device port
package soc_bus_pkg;

    // Host or hub request, strobes are single-cycle pulses
    typedef struct packed {
        logic [31:0] addr;   // Byte address
        logic [31:0] wdata;
        logic [3:0]  wmask;  // One bit per byte lane
        logic        wen;
        logic        ren;
    } bus_req_t;

    // Device response, done follows the strobe by one cycle
    typedef struct packed {
        logic [31:0] rdata;  // Zero for writes
        logic        done;
    } bus_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/soc_map_pkg.sv ====
`default_nettype none

// Address map and register layout of the system
package soc_map_pkg;

    localparam logic [31:0] MEM_BASE  = 32'h0000_0000;  // Word RAM, bit 31 clear
    localparam logic [31:0] PORT_BASE = 32'h8000_0000;  // Parallel port window

    // Port register byte offsets
    localparam logic [31:0] PORT_OUT_OFS = 32'd0;
    localparam logic [31:0] PORT_IN_OFS  = 32'd4;

    // Output register, written as a word and decoded into pin fields
    typedef union packed {
        logic [31:0] word;
        struct packed {
            logic [19:0] reserved;
            logic [3:0]  lcols;  // Bits 11..8
            logic [7:0]  leds;   // Bits 7..0
        } fields;
    } port_out_t;

endpackage

`default_nettype wire

// ==== verilog/debouncer.sv ====
`timescale 1ns/1ps
`default_nettype none

module debouncer #(
    parameter int DEBOUNCE_CYCLES = 12000
) (
    input  logic clk12MHz,
    input  logic rst_n,
    input  logic key,      // Active low pin
    output logic state,    // 1 while held
    output logic pressed   // One-cycle pulse on press
);
    localparam int CW = $clog2(DEBOUNCE_CYCLES + 1);

    logic [1:0]    sync;
    logic [CW-1:0] cnt;
    logic          sample;
    logic          expired;

    assign sample  = ~sync[1];                          // Held = 1
    assign expired = (cnt == CW'(DEBOUNCE_CYCLES - 1));

    always_ff @(posedge clk12MHz) begin
        if (!rst_n) begin
            sync    <= 2'b11;                           // Released
            cnt     <= '0;
            state   <= 1'b0;
            pressed <= 1'b0;
        end else begin
            sync    <= {sync[0], key};
            pressed <= 1'b0;
            if (sample == state) begin
                cnt <= '0;                              // Bounce restarts the count
            end else if (expired) begin
                cnt     <= '0;
                state   <= sample;
                pressed <= sample;
            end else begin
                cnt <= cnt + CW'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/bus_hub.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_hub
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
#(
    parameter int MEMSIZE = 2048
) (
    input  logic     clk12MHz,
    input  logic     rst_n,
    input  bus_req_t host_req,
    output bus_rsp_t host_rsp,
    output bus_req_t mem_req,
    input  bus_rsp_t mem_rsp,
    output bus_req_t port_req,
    input  bus_rsp_t port_rsp
);
    localparam logic [28:0] MEM_WORDS = 29'(MEMSIZE);

    logic strobe;
    logic mem_sel;
    logic port_sel;
    logic none_sel;
    logic mem_q;
    logic port_q;
    logic none_q;

    assign strobe = host_req.wen | host_req.ren;

    // Combinational address decode
    assign mem_sel  = (host_req.addr[31] == MEM_BASE[31]) &&
                      (host_req.addr[30:2] < MEM_WORDS);
    assign port_sel = (host_req.addr[31] == PORT_BASE[31]) &&
                      (host_req.addr[30:3] == PORT_BASE[30:3]);
    assign none_sel = ~mem_sel & ~port_sel;

    // Only the selected device sees a strobe
    always_comb begin
        mem_req      = host_req;
        mem_req.wen  = host_req.wen & mem_sel;
        mem_req.ren  = host_req.ren & mem_sel;
        port_req     = host_req;
        port_req.wen = host_req.wen & port_sel;
        port_req.ren = host_req.ren & port_sel;
    end

    // Target tag for the response cycle
    always_ff @(posedge clk12MHz) begin
        if (!rst_n) begin
            mem_q  <= 1'b0;
            port_q <= 1'b0;
            none_q <= 1'b0;
        end else begin
            mem_q  <= strobe & mem_sel;
            port_q <= strobe & port_sel;
            none_q <= strobe & none_sel;
        end
    end

    always_comb begin
        if (mem_q) begin
            host_rsp = mem_rsp;
        end else if (port_q) begin
            host_rsp = port_rsp;
        end else if (none_q) begin
            host_rsp.rdata = '0;           // Unmapped, answered here
            host_rsp.done  = 1'b1;
        end else begin
            host_rsp = '0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory
    import soc_bus_pkg::*;
#(
    parameter int MEMSIZE = 2048
) (
    input  logic     clk12MHz,
    input  logic     rst_n,
    input  bus_req_t req,
    output bus_rsp_t rsp
);
    localparam int AW = $clog2(MEMSIZE);

    logic [31:0]   ram [0:MEMSIZE-1];
    logic [AW-1:0] idx;
    logic [31:0]   rdata_q;
    logic          done_q;

    assign idx = req.addr[AW+1:2];   // Word index, upper bits ignored

    // Byte-masked write port
    always_ff @(posedge clk12MHz) begin
        if (req.wen) begin
            for (int b = 0; b < 4; b++) begin
                if (req.wmask[b]) begin
                    ram[idx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    // Registered read, zero on writes
    always_ff @(posedge clk12MHz) begin
        if (req.ren) begin
            rdata_q <= ram[idx];
        end else begin
            rdata_q <= '0;
        end
    end

    always_ff @(posedge clk12MHz) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else begin
            done_q <= req.wen | req.ren;
        end
    end

    assign rsp.rdata = rdata_q;
    assign rsp.done  = done_q;

endmodule

`default_nettype wire

// ==== verilog/parallel_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module parallel_port
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
(
    input  logic       clk12MHz,
    input  logic       rst_n,
    input  bus_req_t   req,
    output bus_rsp_t   rsp,
    output logic [7:0] leds,
    output logic [3:0] lcols,
    input  logic [3:0] key_state,
    input  logic [3:0] key_press
);
    port_out_t   out_q;
    logic [3:0]  flags_q;
    logic [3:0]  clr;
    logic [31:0] rdata_q;
    logic        done_q;
    logic        out_sel;
    logic        in_sel;

    assign out_sel = (req.addr[2] == PORT_OUT_OFS[2]);
    assign in_sel  = (req.addr[2] == PORT_IN_OFS[2]);

    // Write-one-to-clear on byte 0 of the input register
    assign clr = (req.wen && in_sel && req.wmask[0]) ? req.wdata[7:4] : 4'b0;

    always_ff @(posedge clk12MHz) begin
        if (!rst_n) begin
            out_q.word <= '0;
            flags_q    <= '0;
            done_q     <= 1'b0;
        end else begin
            if (req.wen && out_sel) begin
                for (int b = 0; b < 4; b++) begin
                    if (req.wmask[b]) begin
                        out_q.word[8*b +: 8] <= req.wdata[8*b +: 8];
                    end
                end
            end
            flags_q <= (flags_q & ~clr) | key_press;  // Set wins over clear
            done_q  <= req.wen | req.ren;
        end
    end

    always_ff @(posedge clk12MHz) begin
        if (req.ren && in_sel) begin
            rdata_q <= {24'b0, flags_q, key_state};
        end else if (req.ren) begin
            rdata_q <= out_q.word;
        end else begin
            rdata_q <= '0;
        end
    end

    assign rsp.rdata = rdata_q;
    assign rsp.done  = done_q;

    assign leds  = out_q.fields.leds;
    assign lcols = out_q.fields.lcols;

endmodule

`default_nettype wire

// ==== verilog/soc_icefun.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_icefun
    import soc_bus_pkg::*;
#(
    parameter int MEMSIZE         = 2048,
    parameter int DEBOUNCE_CYCLES = 12000
) (
    input  logic     clk12MHz,
    input  logic     rst_n,
    input  bus_req_t host_req,
    output bus_rsp_t host_rsp,
    output logic     led1,
    output logic     led2,
    output logic     led3,
    output logic     led4,
    output logic     led5,
    output logic     led6,
    output logic     led7,
    output logic     led8,
    output logic     lcol1,
    output logic     lcol2,
    output logic     lcol3,
    output logic     lcol4,
    input  logic     key1,
    input  logic     key2,
    input  logic     key3,
    input  logic     key4
);
    bus_req_t   mem_req;
    bus_rsp_t   mem_rsp;
    bus_req_t   port_req;
    bus_rsp_t   port_rsp;
    logic [7:0] leds;
    logic [3:0] lcols;
    logic [3:0] key_state;
    logic [3:0] key_press;

    // Pins are active low
    assign {led8, led7, led6, led5, led4, led3, led2, led1} = ~leds;
    assign {lcol4, lcol3, lcol2, lcol1} = ~lcols;

    bus_hub #(
        .MEMSIZE(MEMSIZE)
    ) hub (
        .clk12MHz,
        .rst_n,
        .host_req,
        .host_rsp,
        .mem_req,
        .mem_rsp,
        .port_req,
        .port_rsp
    );

    memory #(
        .MEMSIZE(MEMSIZE)
    ) mem (
        .clk12MHz,
        .rst_n,
        .req(mem_req),
        .rsp(mem_rsp)
    );

    parallel_port pp (
        .clk12MHz,
        .rst_n,
        .req(port_req),
        .rsp(port_rsp),
        .leds,
        .lcols,
        .key_state,
        .key_press
    );

    debouncer #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) k1 (
        .clk12MHz,
        .rst_n,
        .key(key1),
        .state(key_state[0]),
        .pressed(key_press[0])
    );

    debouncer #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) k2 (
        .clk12MHz,
        .rst_n,
        .key(key2),
        .state(key_state[1]),
        .pressed(key_press[1])
    );

    debouncer #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) k3 (
        .clk12MHz,
        .rst_n,
        .key(key3),
        .state(key_state[2]),
        .pressed(key_press[2])
    );

    debouncer #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) k4 (
        .clk12MHz,
        .rst_n,
        .key(key4),
        .state(key_state[3]),
        .pressed(key_press[3])
    );

endmodule

`default_nettype wire

// ==== sim/tb_soc_icefun.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_soc_icefun
    import soc_bus_pkg::*;
();
    localparam int MEMSIZE         = 64;
    localparam int DEBOUNCE_CYCLES = 8;
    localparam int AW              = $clog2(MEMSIZE);

    localparam logic [1:0] OP_WRITE = 2'd0;
    localparam logic [1:0] OP_READ  = 2'd1;
    localparam logic [1:0] OP_KEY   = 2'd2;
    localparam logic [1:0] OP_IDLE  = 2'd3;

    typedef struct packed {
        logic [1:0]  op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wmask;
        logic [3:0]  keys;   // {key4..key1} pin levels
        logic [15:0] hold;   // Cycles for key and idle steps
        logic [31:0] exp;    // Read data or zero for writes
        logic [11:0] pins;   // {lcol4..lcol1, led8..led1}
    } step_t;

    logic        clk12MHz = 1'b0;
    logic        rst_n;
    bus_req_t    host_req;
    bus_rsp_t    host_rsp;
    logic [7:0]  led_pins;
    logic [3:0]  col_pins;
    logic        key1;
    logic        key2;
    logic        key3;
    logic        key4;
    logic [11:0] pins;

    step_t       steps[$];
    string       names[$];
    logic [31:0] ram_model [0:MEMSIZE-1];
    logic [31:0] out_model = '0;
    int          ram_words [0:5] = '{0, 1, 2, 3, 10, 63};
    int          seed = 11;
    int          total_cycles = 0;
    int          limit_ns;
    bit          table_ready = 1'b0;

    always #10 clk12MHz = ~clk12MHz;

    assign pins = {col_pins, led_pins};

    soc_icefun #(
        .MEMSIZE(MEMSIZE),
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) i_soc_icefun (
        .clk12MHz, .rst_n, .host_req, .host_rsp,
        .led1(led_pins[0]), .led2(led_pins[1]), .led3(led_pins[2]), .led4(led_pins[3]),
        .led5(led_pins[4]), .led6(led_pins[5]), .led7(led_pins[6]), .led8(led_pins[7]),
        .lcol1(col_pins[0]), .lcol2(col_pins[1]), .lcol3(col_pins[2]), .lcol4(col_pins[3]),
        .key1, .key2, .key3, .key4
    );

    function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] data,
                                                logic [3:0] mask);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) res[8*b +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    task automatic add_step(string name, logic [1:0] op, logic [31:0] addr,
                            logic [31:0] data, logic [3:0] mask, logic [3:0] keys,
                            logic [15:0] hold, logic [31:0] exp);
        steps.push_back('{op, addr, data, mask, keys, hold, exp, ~out_model[11:0]});
        names.push_back(name);
        total_cycles += (op == OP_WRITE || op == OP_READ) ? 1 : int'(hold);
    endtask

    task automatic add_write(string name, logic [31:0] addr, logic [31:0] data,
                             logic [3:0] mask);
        if (!addr[31] && addr[30:2] < 29'(MEMSIZE)) begin
            ram_model[addr[AW+1:2]] = merge_bytes(ram_model[addr[AW+1:2]], data, mask);
        end
        if (addr[31] && addr[30:3] == 28'd0 && !addr[2]) begin
            out_model = merge_bytes(out_model, data, mask);  // Output register
        end
        add_step(name, OP_WRITE, addr, data, mask, 4'hF, 16'd1, 32'd0);
    endtask

    task automatic add_read(string name, logic [31:0] addr, logic [31:0] exp);
        add_step(name, OP_READ, addr, 32'd0, 4'h0, 4'hF, 16'd1, exp);
    endtask

    task automatic add_ram_read(string name, logic [31:0] addr);
        add_read(name, addr, ram_model[addr[AW+1:2]]);
    endtask

    task automatic build_table();
        add_step("reset_state", OP_IDLE, 32'd0, 32'd0, 4'h0, 4'hF, 16'd2, 32'd0);
        for (int k = 0; k < 6; k++) begin
            add_write($sformatf("ram_fill_%0d", k), 32'(ram_words[k] * 4), $random(seed), 4'hF);
        end
        for (int k = 0; k < 6; k++) begin
            add_write($sformatf("ram_masked_%0d", k), 32'(ram_words[k] * 4), $random(seed),
                      4'($random(seed)));
        end
        for (int k = 0; k < 6; k++) begin
            add_ram_read($sformatf("ram_read_%0d", k), 32'(ram_words[k] * 4));
        end
        add_ram_read("ram_read_byte_ofs", 32'd43);        // Low address bits ignored
        add_write("out_low_half", 32'h8000_0000, 32'h0000_0A5C, 4'b0011);
        add_write("out_byte0", 32'h8000_0000, 32'hFFFF_FF33, 4'b0001);
        add_write("out_mid_bytes", 32'h8000_0000, 32'h1234_0500, 4'b0110);
        add_read("out_read", 32'h8000_0000, out_model);
        add_write("unmapped_wr_hi", 32'h4000_0000, $random(seed), 4'hF);
        add_write("unmapped_wr_ram", 32'(MEMSIZE * 4), 32'hDEAD_BEEF, 4'hF);
        add_write("unmapped_wr_port", 32'h8000_0008, 32'hFFFF_FFFF, 4'hF);
        add_read("unmapped_rd_hi", 32'h4000_0000, 32'd0);
        add_read("unmapped_rd_ram", 32'(MEMSIZE * 4), 32'd0);
        add_read("unmapped_rd_port", 32'h8000_0008, 32'd0);
        add_ram_read("ram_word0_kept", 32'd0);
        add_step("key_short", OP_KEY, 32'd0, 32'd0, 4'h0, 4'b1110,
                 16'(DEBOUNCE_CYCLES - 1), 32'd0);
        add_step("key_short_off", OP_KEY, 32'd0, 32'd0, 4'h0, 4'b1111, 16'd12, 32'd0);
        add_read("key_short_ignored", 32'h8000_0004, 32'h0000_0000);
        add_step("key_hold", OP_KEY, 32'd0, 32'd0, 4'h0, 4'b1010, 16'd14, 32'd0);
        add_read("key_held", 32'h8000_0004, 32'h0000_0055);
        add_step("key_release", OP_KEY, 32'd0, 32'd0, 4'h0, 4'b1111, 16'd14, 32'd0);
        add_read("key_flags_sticky", 32'h8000_0004, 32'h0000_0050);
        add_write("flag_clear_k1", 32'h8000_0004, 32'h0000_0010, 4'b0001);
        add_read("flag_k3_left", 32'h8000_0004, 32'h0000_0040);
        add_write("flag_clear_nomask", 32'h8000_0004, 32'h0000_0040, 4'b1110);
        add_read("flag_k3_kept", 32'h8000_0004, 32'h0000_0040);
        add_write("flag_clear_all", 32'h8000_0004, 32'h0000_00F0, 4'b0001);
        add_read("flags_empty", 32'h8000_0004, 32'h0000_0000);
        add_step("final_idle", OP_IDLE, 32'd0, 32'd0, 4'h0, 4'hF, 16'd2, 32'd0);
    endtask

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        assert (act === exp) else begin
            $display("Error: %s expected 0x%08h actual 0x%08h", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    // Watchdog sized from the table
    initial begin
        wait (table_ready);
        #(limit_ns);
        $display("Timeout: the tests did not finish within %0d ns", limit_ns);
        $display("STATUS: FAIL");
        $fatal(1);
    end

    initial begin
        step_t s;
        int    ncyc;
        host_req = '0;
        {key4, key3, key2, key1} = 4'hF;   // Keys released
        rst_n = 1'b0;
        build_table();
        limit_ns = (total_cycles + 2 + 50) * 20;
        table_ready = 1'b1;
        repeat (2) @(posedge clk12MHz);
        #2;
        rst_n = 1'b1;
        for (int i = 0; i < steps.size(); i++) begin
            s = steps[i];
            ncyc = (s.op == OP_WRITE || s.op == OP_READ) ? 1 : int'(s.hold);
            host_req.addr  = s.addr;
            host_req.wdata = s.wdata;
            host_req.wmask = s.wmask;
            host_req.wen   = (s.op == OP_WRITE);
            host_req.ren   = (s.op == OP_READ);
            if (s.op == OP_KEY) {key4, key3, key2, key1} = s.keys;
            for (int c = 0; c < ncyc; c++) begin
                @(posedge clk12MHz);
                #1;                                          // Sample before next drive
                if (s.op == OP_WRITE || s.op == OP_READ) begin
                    check_value({names[i], " done"}, 32'd1, 32'(host_rsp.done));
                    check_value({names[i], " rdata"}, s.exp, host_rsp.rdata);
                end else begin
                    check_value({names[i], " done"}, 32'd0, 32'(host_rsp.done));
                end
                check_value({names[i], " pins"}, 32'(s.pins), 32'(pins));
                #1;
                host_req = '0;
            end
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/soc_bus_pkg.sv
verilog/soc_map_pkg.sv
verilog/debouncer.sv
verilog/bus_hub.sv
verilog/memory.sv
verilog/parallel_port.sv
verilog/soc_icefun.sv
sim/tb_soc_icefun.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it into sim.log and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_soc_icefun \
    -Mdir obj_dir -o tb_soc_icefun \
    && ./obj_dir/tb_soc_icefun > sim.log 2>&1

cat sim.log 2>/dev/null
grep -qx "STATUS: PASS" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
